// File: hdl/add_mod_2nm1.sv
// combinational adder modulo 2^n-1 with end-around carry, zero is always all zeros
`timescale 1ns/1ps

module add_mod_2nm1 import arith_pkg::*; #(
	parameter speed_e speed = FAST // prefix tree form
) (
	input  logic [sum_width-1:0] a,   // operands, 0xff treated as zero
	input  logic [sum_width-1:0] b,
	output logic [sum_width-1:0] sum  // never all ones
);

	logic [sum_width-1:0] gen_bit;   // a & b
	logic [sum_width-1:0] prop_bit;  // a | b
	logic [sum_width-1:0] half_sum;  // a ^ b
	logic [sum_width-1:0] grp_gen;   // prefix results
	logic [sum_width-1:0] grp_prop;
	logic                 carry_end; // wrapped carry into bit 0
	logic [sum_width-2:0] carry;     // carry into bits 1..n-1

	assign gen_bit  = a & b;
	assign prop_bit = a | b;
	assign half_sum = ~gen_bit & prop_bit;

	prefix_and_or #(
		.speed(speed)
	) i_prefix (
		.gen_in  (gen_bit),
		.prop_in (prop_bit),
		.gen_out (grp_gen),
		.prop_out(grp_prop)
	);

	// real carry out, or a full propagate chain which would land on all ones
	assign carry_end = grp_gen[sum_width-1] | grp_prop[sum_width-1];

	// extra prefix level folds the end-around carry back in
	assign carry = grp_gen[sum_width-2:0]
		| (grp_prop[sum_width-2:0] & {(sum_width - 1){carry_end}});

	assign sum = half_sum ^ {carry, carry_end};

endmodule

// File: hdl/arith_pkg.sv
// arithmetic types and widths shared by the modular adder and its prefix carry tree
package arith_pkg;

	// prefix tree flavour, trades depth against cell count
	typedef enum logic [1:0] {
		SLOW   = 2'b00, // serial ripple chain
		MEDIUM = 2'b01, // brent-kung
		FAST   = 2'b10  // sklansky
	} speed_e;

	// adder word and fletcher sum width
	localparam int sum_width = 8;

	// log2 levels of the tree forms
	localparam int sum_depth = $clog2(sum_width);

endpackage

// File: hdl/csum_apb_regs.sv
// apb4 slave for the checksum engine, decodes registers and feeds strobed bytes with wait states
`timescale 1ns/1ps

module csum_apb_regs import csum_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [3:0]             paddr,
	input  logic [31:0]            pwdata,
	input  logic [3:0]             pstrb,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	output logic                   clear,      // pulse to the datapath
	output logic                   byte_valid,
	output logic [7:0]             byte_data,
	input  logic [7:0]             sum_a,
	input  logic [7:0]             sum_b,
	input  logic [count_width-1:0] byte_count
);

	reg_state_e state_q, state_d;
	logic [31:0] word_q;        // latched data word
	logic [3:0]  strb_q;        // lanes still to send
	logic [3:0]  strb_d;
	logic        access;        // apb access phase
	logic        idle_access;   // new transfer, decode applies
	logic        data_wr;       // data write seen in its first access cycle
	logic        bad;           // decode error
	logic [3:0]  cur_strb;      // lanes pending this cycle
	logic [31:0] cur_word;
	logic [3:0]  rest_strb;     // cur_strb with lowest lane dropped
	logic [1:0]  lane;          // lowest pending lane
	cmd_e        cmd;

	assign access      = psel & penable;
	assign idle_access = access & (state_q == REG_IDLE);
	assign data_wr     = idle_access & pwrite & (paddr == addr_data);
	assign cmd         = cmd_e'(pwdata[0]);

	// first byte comes straight off the bus, later ones from the latch
	assign cur_strb  = (state_q == REG_IDLE) ? pstrb : strb_q;
	assign cur_word  = (state_q == REG_IDLE) ? pwdata : word_q;
	assign rest_strb = cur_strb & (cur_strb - 4'd1);

	// priority pick, lane 0 first
	always_comb begin
		lane = 2'd0;
		if (cur_strb[0])
			lane = 2'd0;
		else if (cur_strb[1])
			lane = 2'd1;
		else if (cur_strb[2])
			lane = 2'd2;
		else if (cur_strb[3])
			lane = 2'd3;
	end

	assign byte_data  = cur_word[lane*8 +: 8];
	assign byte_valid = ((state_q == REG_FEED) ? access : data_wr) & (|cur_strb);

	// decode errors, checked only when a transfer starts
	always_comb begin
		case (paddr)
			addr_ctrl:               bad = pwrite && (pwdata[31:1] != '0); // reserved bits
			addr_data:               bad = 1'b0;
			addr_result, addr_count: bad = pwrite;                         // read only
			default:                 bad = 1'b1;                           // unmapped
		endcase
	end

	assign clear = idle_access & pwrite & (paddr == addr_ctrl) & ~bad & (cmd == CMD_CLEAR);

	always_comb begin
		state_d = state_q;
		strb_d  = strb_q;
		pready  = 1'b0;
		pslverr = 1'b0;
		case (state_q)
			REG_IDLE: begin
				if (data_wr && (|pstrb)) begin
					state_d = REG_FEED; // wait states until every lane is out
					strb_d  = rest_strb;
				end else if (idle_access) begin
					pready  = 1'b1;     // everything else is zero wait
					pslverr = bad;
				end
			end
			REG_FEED: begin
				if (strb_q == '0) begin
					pready  = access;
					state_d = REG_IDLE;
				end else begin
					strb_d = rest_strb; // one lane per cycle
				end
			end
			default: state_d = REG_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= REG_IDLE;
			strb_q  <= '0;
		end else begin
			state_q <= state_d;
			strb_q  <= strb_d;
		end
	end

	always_ff @(posedge clk) begin
		if (data_wr)
			word_q <= pwdata; // payload only
	end

	// read mux, zero extended
	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			case (paddr)
				addr_result: prdata = 32'({sum_b, sum_a});
				addr_count:  prdata = 32'(byte_count);
				default:     prdata = '0;
			endcase
		end
	end

	a_err_ready: assert property (@(posedge clk) disable iff (!arst_n)
		pslverr |-> pready)
		else $error("pslverr without pready");

	a_feed_in_access: assert property (@(posedge clk) disable iff (!arst_n)
		byte_valid |-> (psel && penable))
		else $error("byte sent outside an apb access");

endmodule

// File: hdl/csum_pkg.sv
// register map, control opcodes and register-block states of the apb checksum engine
package csum_pkg;

	// apb register offsets, byte addresses in a 4 bit window
	localparam logic [3:0] addr_ctrl   = 4'h0; // bit 0 issues a clear
	localparam logic [3:0] addr_data   = 4'h4; // strobed bytes, lane 0 first
	localparam logic [3:0] addr_result = 4'h8; // ro, {sum_b, sum_a}
	localparam logic [3:0] addr_count  = 4'hC; // ro, byte count in 15:0

	// running byte counter width, wraps silently
	localparam int count_width = 16;

	// control word opcode, taken from bit 0
	typedef enum logic {
		CMD_NOP   = 1'b0,
		CMD_CLEAR = 1'b1
	} cmd_e;

	// register block fsm
	typedef enum logic {
		REG_IDLE = 1'b0, // waiting for an access
		REG_FEED = 1'b1  // pushing latched lanes into the datapath
	} reg_state_e;

endpackage

// File: hdl/csum_top.sv
// top level of the apb fletcher-16 engine, register block driving the sum datapath
`timescale 1ns/1ps

module csum_top import arith_pkg::*; import csum_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	input  logic [3:0]  pstrb,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	logic                   clear;      // regs -> datapath
	logic                   byte_valid;
	logic [sum_width-1:0]   byte_data;
	logic [sum_width-1:0]   sum_a;      // datapath -> regs
	logic [sum_width-1:0]   sum_b;
	logic [count_width-1:0] byte_count;

	csum_apb_regs i_regs (
		.clk       (clk),
		.arst_n    (arst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.pstrb     (pstrb),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.clear     (clear),
		.byte_valid(byte_valid),
		.byte_data (byte_data),
		.sum_a     (sum_a),
		.sum_b     (sum_b),
		.byte_count(byte_count)
	);

	fletcher_datapath i_datapath (
		.clk       (clk),
		.arst_n    (arst_n),
		.clear     (clear),
		.byte_valid(byte_valid),
		.byte_data (byte_data),
		.sum_a     (sum_a),
		.sum_b     (sum_b),
		.byte_count(byte_count)
	);

endmodule

// File: hdl/fletcher_datapath.sv
// fletcher-16 running sums and byte counter, one byte per cycle from the register block
`timescale 1ns/1ps

module fletcher_datapath import arith_pkg::*; import csum_pkg::*; (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   clear,      // one cycle, wins over a byte
	input  logic                   byte_valid,
	input  logic [sum_width-1:0]   byte_data,
	output logic [sum_width-1:0]   sum_a,      // sum of bytes mod 255
	output logic [sum_width-1:0]   sum_b,      // sum of sum_a mod 255
	output logic [count_width-1:0] byte_count  // wraps at 2^16
);

	logic [sum_width-1:0] next_a; // sum_a + byte
	logic [sum_width-1:0] next_b; // sum_b + next_a

	// short path for the byte add
	add_mod_2nm1 #(
		.speed(FAST)
	) i_add_a (
		.a  (sum_a),
		.b  (byte_data),
		.sum(next_a)
	);

	// chained behind i_add_a, cheaper tree
	add_mod_2nm1 #(
		.speed(MEDIUM)
	) i_add_b (
		.a  (sum_b),
		.b  (next_a),
		.sum(next_b)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sum_a      <= '0;
			sum_b      <= '0;
			byte_count <= '0;
		end else if (clear) begin
			sum_a      <= '0;
			sum_b      <= '0;
			byte_count <= '0;
		end else if (byte_valid) begin
			sum_a      <= next_a;
			sum_b      <= next_b;
			byte_count <= byte_count + 1'b1; // free running wrap
		end
	end

	// single zero representation across both adders
	a_no_ones: assert property (@(posedge clk) disable iff (!arst_n)
		(sum_a != '1) && (sum_b != '1))
		else $error("fletcher sum reached 0xff");

	a_clear_zero: assert property (@(posedge clk) disable iff (!arst_n)
		clear |=> (sum_a == '0) && (sum_b == '0) && (byte_count == '0))
		else $error("clear did not zero the datapath");

endmodule

// File: hdl/prefix_and_or.sv
// group generate/propagate prefix tree from bit 0 to every position, speed picks the topology
`timescale 1ns/1ps

module prefix_and_or import arith_pkg::*; #(
	parameter speed_e speed = FAST // tree form
) (
	input  logic [sum_width-1:0] gen_in,   // bitwise generate
	input  logic [sum_width-1:0] prop_in,  // bitwise propagate
	output logic [sum_width-1:0] gen_out,  // group generate 0..i
	output logic [sum_width-1:0] prop_out  // group propagate 0..i
);

	// both tree forms assume full binary levels
	if (speed != SLOW) begin : g_width_check
		initial begin
			assert (sum_width == (1 << sum_depth))
				else $error("prefix tree width %0d is not a power of two", sum_width);
		end
	end

	if (speed == FAST) begin : g_sklansky
		logic [sum_width-1:0] g_t [sum_depth+1]; // one row per level
		logic [sum_width-1:0] p_t [sum_depth+1];

		assign g_t[0] = gen_in;
		assign p_t[0] = prop_in;

		for (genvar l = 1; l <= sum_depth; l++) begin : g_lvl
			for (genvar i = 0; i < sum_width; i++) begin : g_bit
				// upper half of each 2^l block pulls from the top of the lower half
				if (((i >> (l - 1)) % 2) == 1) begin : g_black
					assign g_t[l][i] = g_t[l-1][i]
						| (p_t[l-1][i] & g_t[l-1][((i >> (l - 1)) << (l - 1)) - 1]);
					assign p_t[l][i] = p_t[l-1][i]
						& p_t[l-1][((i >> (l - 1)) << (l - 1)) - 1];
				end else begin : g_white
					assign g_t[l][i] = g_t[l-1][i]; // pass through
					assign p_t[l][i] = p_t[l-1][i];
				end
			end
		end

		assign gen_out  = g_t[sum_depth];
		assign prop_out = p_t[sum_depth];
	end else if (speed == MEDIUM) begin : g_brent_kung
		// up-sweep rows 1..depth, down-sweep rows depth+1..2*depth-1
		logic [sum_width-1:0] g_t [2*sum_depth];
		logic [sum_width-1:0] p_t [2*sum_depth];

		assign g_t[0] = gen_in;
		assign p_t[0] = prop_in;

		for (genvar l = 1; l <= sum_depth; l++) begin : g_up
			for (genvar i = 0; i < sum_width; i++) begin : g_bit
				if (((i + 1) % (2 ** l)) == 0) begin : g_black
					// block top merges with the top of its left neighbour
					assign g_t[l][i] = g_t[l-1][i]
						| (p_t[l-1][i] & g_t[l-1][i - 2 ** (l - 1)]);
					assign p_t[l][i] = p_t[l-1][i] & p_t[l-1][i - 2 ** (l - 1)];
				end else begin : g_white
					assign g_t[l][i] = g_t[l-1][i];
					assign p_t[l][i] = p_t[l-1][i];
				end
			end
		end

		for (genvar l = sum_depth + 1; l < 2 * sum_depth; l++) begin : g_down
			for (genvar i = 0; i < sum_width; i++) begin : g_bit
				// fill in the mid points, span halves each row
				if ((i >= 2 ** (2 * sum_depth - l))
					&& (((i + 1) % (2 ** (2 * sum_depth - l)))
						== 2 ** (2 * sum_depth - l - 1))) begin : g_black
					assign g_t[l][i] = g_t[l-1][i]
						| (p_t[l-1][i] & g_t[l-1][i - 2 ** (2 * sum_depth - l - 1)]);
					assign p_t[l][i] = p_t[l-1][i]
						& p_t[l-1][i - 2 ** (2 * sum_depth - l - 1)];
				end else begin : g_white
					assign g_t[l][i] = g_t[l-1][i];
					assign p_t[l][i] = p_t[l-1][i];
				end
			end
		end

		assign gen_out  = g_t[2*sum_depth-1];
		assign prop_out = p_t[2*sum_depth-1];
	end else begin : g_serial
		logic [sum_width-1:0] g_s; // ripple chain
		logic [sum_width-1:0] p_s;

		assign g_s[0] = gen_in[0];
		assign p_s[0] = prop_in[0];

		for (genvar i = 1; i < sum_width; i++) begin : g_bit
			assign g_s[i] = gen_in[i] | (prop_in[i] & g_s[i-1]);
			assign p_s[i] = prop_in[i] & p_s[i-1];
		end

		assign gen_out  = g_s;
		assign prop_out = p_s;
	end

endmodule

// File: project.f
+incdir+sim
hdl/arith_pkg.sv
hdl/csum_pkg.sv
hdl/prefix_and_or.sv
hdl/add_mod_2nm1.sv
hdl/fletcher_datapath.sv
hdl/csum_apb_regs.sv
hdl/csum_top.sv
sim/tb_csum.sv

// File: run_sim.sh
#!/bin/sh
# build the checksum testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Simulation failed"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_csum -f project.f -Mdir obj_dir -o tb_csum
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/tb_csum > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
	echo "run failed, see $LOG"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "simulator exited with status $run_status"
	exit 1
fi

echo "run passed"
exit 0

// File: sim/tb_apb_tasks.svh
// apb master transfer task, lane count and xorshift generator, included inside the checksum testbench
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// xorshift32 step, nonzero seed never reaches zero
function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// number of strobed lanes, also the expected wait states of a data write
function automatic int count_lanes(input logic [3:0] strb);
	int n;
	n = 0;
	for (int i = 0; i < 4; i++)
		n += int'(strb[i]);
	return n;
endfunction

// one apb transfer, expectations for the checkers go out with the setup phase
task automatic apb_xfer(
	input logic        write,
	input logic [3:0]  addr,
	input logic [31:0] data,
	input logic [3:0]  strb,
	input logic        err,   // pslverr expected at completion
	input logic        chk,   // compare prdata
	input logic [31:0] rdata,
	input int          waits  // access cycles before pready
);
	psel      = 1'b1; // setup
	penable   = 1'b0;
	pwrite    = write;
	paddr     = addr;
	pwdata    = data;
	pstrb     = strb;
	exp_err   = err;
	exp_chk   = chk;
	exp_rdata = rdata;
	exp_waits = waits;
	@(posedge clk);
	#0.5;
	penable = 1'b1; // first access cycle
	do
		@(negedge clk); // pready settled mid cycle
	while (!pready);
	@(posedge clk);
	#0.5;
	psel    = 1'b0;
	penable = 1'b0;
	pstrb   = '0;
	exp_chk = 1'b0;
	@(posedge clk); // idle cycle between transfers
	#0.5;
endtask

`endif

// File: sim/tb_csum.sv
// testbench for the apb fletcher-16 engine, random and corner streams checked by concurrent assertions
`timescale 1ns/1ps

module tb_csum import csum_pkg::*; ;

	localparam int n_rand        = 200; // random data words
	localparam int n_after_clear = 10;
	localparam int n_edge        = 20;  // 0xff words and complement pairs each
	localparam int n_xfers       = 2 + 3 * n_rand + 3 + 2 * n_after_clear + 8 + 4 * n_edge;
	localparam int timeout_cycles = n_xfers * 8 + 200;

	logic        clk = 1'b0;
	logic        arst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [3:0]  pstrb;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	logic        exp_err;     // pending expectations from the apb task
	logic        exp_chk;
	logic [31:0] exp_rdata;
	int          exp_waits;
	int          acc_cnt;     // access cycles so far in this transfer
	logic        xfer_done;
	int          ref_a;       // reference sums, 0..254
	int          ref_b;
	logic [15:0] ref_count;
	logic [31:0] rng;

	always #2 clk = ~clk; // 4 ns period

	csum_top i_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.paddr  (paddr),
		.pwdata (pwdata),
		.pstrb  (pstrb),
		.prdata (prdata),
		.pready (pready),
		.pslverr(pslverr)
	);

	task automatic report_error(input string msg);
		$display("error: %0t ns %s", $time, msg);
		$display("Simulation failed");
		$fatal(1, "check failed");
	endtask

	`include "tb_apb_tasks.svh"

	// fletcher rule, 255 folds to 0
	task automatic model_byte(input logic [7:0] b);
		ref_a     = (ref_a + int'(b)) % 255;
		ref_b     = (ref_b + ref_a) % 255;
		ref_count = ref_count + 16'd1;
	endtask

	task automatic write_data(input logic [31:0] word, input logic [3:0] strb);
		for (int i = 0; i < 4; i++)
			if (strb[i])
				model_byte(word[8*i +: 8]); // lane 0 first
		apb_xfer(1'b1, addr_data, word, strb, 1'b0, 1'b0, '0, count_lanes(strb));
	endtask

	task automatic write_ctrl(input logic [31:0] word);
		logic err;
		err = (word[31:1] != '0); // reserved bits
		if (!err && word[0]) begin
			ref_a     = 0;
			ref_b     = 0;
			ref_count = '0;
		end
		apb_xfer(1'b1, addr_ctrl, word, 4'hF, err, 1'b0, '0, 0);
	endtask

	task automatic read_result();
		apb_xfer(1'b0, addr_result, '0, 4'h0, 1'b0, 1'b1,
			{16'h0, 8'(ref_b), 8'(ref_a)}, 0);
	endtask

	task automatic read_count();
		apb_xfer(1'b0, addr_count, '0, 4'h0, 1'b0, 1'b1, {16'h0, ref_count}, 0);
	endtask

	// must end in pslverr with no side effect
	task automatic bad_access(input logic write, input logic [3:0] addr);
		apb_xfer(write, addr, 32'hA5A5_0001, write ? 4'hF : 4'h0, 1'b1, 1'b0, '0, 0);
	endtask

	assign xfer_done = psel & penable & pready;

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			acc_cnt <= 0;
		else if (psel && penable && !pready)
			acc_cnt <= acc_cnt + 1; // a wait state
		else
			acc_cnt <= 0;
	end

	a_quiet_outside: assert property (@(posedge clk) disable iff (!arst_n)
		!(psel && penable) |-> !pready && !pslverr)
		else report_error("pready or pslverr outside an access phase");

	a_read_data: assert property (@(posedge clk) disable iff (!arst_n)
		(xfer_done && exp_chk) |-> (prdata == exp_rdata))
		else report_error($sformatf("read %08h, expected %08h", prdata, exp_rdata));

	a_slave_err: assert property (@(posedge clk) disable iff (!arst_n)
		xfer_done |-> (pslverr == exp_err))
		else report_error($sformatf("pslverr %0b, expected %0b", pslverr, exp_err));

	a_wait_states: assert property (@(posedge clk) disable iff (!arst_n)
		xfer_done |-> (acc_cnt == exp_waits))
		else report_error($sformatf("%0d wait states, expected %0d", acc_cnt, exp_waits));

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("watchdog timed out after %0d cycles, a transfer never completed",
			timeout_cycles);
		$display("Simulation failed");
		$fatal(1, "timeout");
	end

	initial begin
		logic [31:0] word;
		arst_n    = 1'b0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		pstrb     = '0;
		exp_err   = 1'b0;
		exp_chk   = 1'b0;
		exp_rdata = '0;
		exp_waits = 0;
		ref_a     = 0;
		ref_b     = 0;
		ref_count = '0;
		rng       = 32'he0fb_6b6c;
		repeat (16) @(posedge clk);
		#0.5;
		arst_n = 1'b1;
		@(posedge clk);
		#0.5;
		read_result(); // zero after reset
		read_count();
		for (int i = 0; i < n_rand; i++) begin
			rng  = xorshift32(rng);
			word = rng;
			rng  = xorshift32(rng);
			write_data(word, rng[19:16]); // includes empty strobes
			read_result();
			read_count();
		end
		write_ctrl(32'(CMD_CLEAR));
		read_result();
		read_count();
		for (int i = 0; i < n_after_clear; i++) begin
			rng = xorshift32(rng);
			write_data(rng, rng[27:24]); // continues from zero
			read_result();
		end
		bad_access(1'b1, addr_result); // read only
		bad_access(1'b1, addr_count);
		bad_access(1'b1, 4'h6);        // unmapped
		bad_access(1'b0, 4'h3);
		write_ctrl(32'h0000_0003);     // clear with reserved bit, ignored
		write_ctrl(32'h8000_0000);
		read_result();
		read_count();
		for (int i = 0; i < n_edge; i++) begin
			write_data(32'hFFFF_FFFF, 4'hF); // 0xff folds to zero
			read_result();
			rng  = xorshift32(rng);
			word = {~rng[15:8], rng[15:8], ~rng[7:0], rng[7:0]}; // pairs add to 255
			write_data(word, 4'hF);
			read_result();
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
